// File: source/mmu_pkg.sv
package mmu_pkg;

    // AXI request field widths
    localparam int ID_WIDTH       = 5;
    localparam int IN_ADDR_WIDTH  = 33;
    // Extra top bit carries the error flag downstream
    localparam int OUT_ADDR_WIDTH = IN_ADDR_WIDTH + 1;

    // Index is the ID bits just below the MSB, then the top address bits
    localparam int ID_BITS_USED       = 4;
    localparam int ADDR_BITS_REMAPPED = 7;
    localparam int INDEX_WIDTH        = ID_BITS_USED + ADDR_BITS_REMAPPED;
    // Physical page plus error flag in the MSB
    localparam int ENTRY_WIDTH        = ADDR_BITS_REMAPPED + 1;
    localparam int TABLE_DEPTH        = 2 ** INDEX_WIDTH;

    typedef logic [ID_WIDTH-1:0]       axi_id_t;
    typedef logic [IN_ADDR_WIDTH-1:0]  in_addr_t;
    typedef logic [OUT_ADDR_WIDTH-1:0] out_addr_t;
    typedef logic [7:0]                burst_len_t;
    typedef logic [2:0]                burst_size_t;
    typedef logic [1:0]                burst_type_t;
    typedef logic [INDEX_WIDTH-1:0]    table_index_t;
    typedef logic [ENTRY_WIDTH-1:0]    table_entry_t;
    typedef logic [31:0]               ctrl_word_t;
    typedef logic [1:0]                axi_resp_t;

    // Control word map, write table first then read table
    localparam int CTRL_WRITE_TABLE_BASE = 0;
    localparam int CTRL_READ_TABLE_BASE  = TABLE_DEPTH;
    localparam int CTRL_WORD_COUNT       = 2 * TABLE_DEPTH;

    localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

// File: source/mmu_ctrl_slave.sv
`timescale 1ns/10ps

module mmu_ctrl_slave import mmu_pkg::*; (
    input  logic         aclk,
    input  logic         aresetn,
    // AXI-Lite write address and data
    input  ctrl_word_t   ctrl_awaddr,
    input  logic         ctrl_awvalid,
    output logic         ctrl_awready,
    input  ctrl_word_t   ctrl_wdata,
    input  logic         ctrl_wvalid,
    output logic         ctrl_wready,
    // Write response
    output axi_resp_t    ctrl_bresp,
    output logic         ctrl_bvalid,
    input  logic         ctrl_bready,
    // Read address and read data
    input  ctrl_word_t   ctrl_araddr,
    input  logic         ctrl_arvalid,
    output logic         ctrl_arready,
    output ctrl_word_t   ctrl_rdata,
    output axi_resp_t    ctrl_rresp,
    output logic         ctrl_rvalid,
    input  logic         ctrl_rready,
    // Write port shared by both tables
    output logic         aw_tbl_wr_en,
    output logic         ar_tbl_wr_en,
    output table_index_t tbl_wr_index,
    output table_entry_t tbl_wr_entry,
    // Readback port shared by both tables
    output logic         aw_tbl_rd_en,
    output logic         ar_tbl_rd_en,
    output table_index_t tbl_rd_index,
    input  table_entry_t aw_tbl_rd_entry,
    input  table_entry_t ar_tbl_rd_entry
);

    typedef enum logic {IDLE, RESPOND} ctrl_state_t;

    ctrl_state_t wr_state;
    ctrl_state_t rd_state;
    logic [29:0] wr_word;
    logic [29:0] rd_word;
    logic        wr_aw_hit;
    logic        wr_ar_hit;
    logic        rd_aw_hit;
    logic        rd_ar_hit;
    logic        wr_fire;
    logic        rd_fire;
    logic        rd_sel_aw;
    logic        rd_sel_ar;

    // Byte address to word number
    assign wr_word = ctrl_awaddr[31:2];
    assign rd_word = ctrl_araddr[31:2];

    // Which table a word falls in, none when past the map
    assign wr_aw_hit = wr_word >= CTRL_WRITE_TABLE_BASE && wr_word < CTRL_READ_TABLE_BASE;
    assign wr_ar_hit = wr_word >= CTRL_READ_TABLE_BASE && wr_word < CTRL_WORD_COUNT;
    assign rd_aw_hit = rd_word >= CTRL_WRITE_TABLE_BASE && rd_word < CTRL_READ_TABLE_BASE;
    assign rd_ar_hit = rd_word >= CTRL_READ_TABLE_BASE && rd_word < CTRL_WORD_COUNT;

    // Handshake cycles
    assign wr_fire = ctrl_awready && ctrl_awvalid && ctrl_wready && ctrl_wvalid;
    assign rd_fire = ctrl_arready && ctrl_arvalid;

    // Table write lands on the handshake edge
    assign aw_tbl_wr_en = wr_fire && wr_aw_hit;
    assign ar_tbl_wr_en = wr_fire && wr_ar_hit;
    // Base is aligned, so the low word bits are the index
    assign tbl_wr_index = wr_word[INDEX_WIDTH-1:0];
    assign tbl_wr_entry = ctrl_wdata[ENTRY_WIDTH-1:0];

    assign aw_tbl_rd_en = rd_fire && rd_aw_hit;
    assign ar_tbl_rd_en = rd_fire && rd_ar_hit;
    assign tbl_rd_index = rd_word[INDEX_WIDTH-1:0];

    // Always OKAY, out of range included
    assign ctrl_bresp  = RESP_OKAY;
    assign ctrl_rresp  = RESP_OKAY;
    assign ctrl_bvalid = wr_state == RESPOND;
    assign ctrl_rvalid = rd_state == RESPOND;

    // Write side
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ctrl_awready <= 1'b0;
            ctrl_wready  <= 1'b0;
            wr_state     <= IDLE;
        end else begin
            // One-cycle pulse, address and data taken together
            ctrl_awready <= wr_state == IDLE && !ctrl_awready && ctrl_awvalid && ctrl_wvalid;
            ctrl_wready  <= wr_state == IDLE && !ctrl_awready && ctrl_awvalid && ctrl_wvalid;
            case (wr_state)
                IDLE:    if (wr_fire) wr_state <= RESPOND;
                RESPOND: if (ctrl_bready) wr_state <= IDLE;
                default: wr_state <= IDLE;
            endcase
        end
    end

    // Read side
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ctrl_arready <= 1'b0;
            rd_state     <= IDLE;
            rd_sel_aw    <= 1'b0;
            rd_sel_ar    <= 1'b0;
        end else begin
            ctrl_arready <= rd_state == IDLE && !ctrl_arready && ctrl_arvalid;
            case (rd_state)
                IDLE: begin
                    if (rd_fire) begin
                        rd_state  <= RESPOND;
                        // Remember the source for the data mux
                        rd_sel_aw <= rd_aw_hit;
                        rd_sel_ar <= rd_ar_hit;
                    end
                end
                RESPOND: if (ctrl_rready) rd_state <= IDLE;
                default: rd_state <= IDLE;
            endcase
        end
    end

    // Entry zero-extended, zero when out of range
    always_comb begin
        if (rd_sel_aw) begin
            ctrl_rdata = ctrl_word_t'(aw_tbl_rd_entry);
        end else if (rd_sel_ar) begin
            ctrl_rdata = ctrl_word_t'(ar_tbl_rd_entry);
        end else begin
            ctrl_rdata = '0;
        end
    end

    // Write response waits for ready, no new write taken meanwhile
    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        ctrl_bvalid && !ctrl_bready |=> ctrl_bvalid && !ctrl_awready && !ctrl_wready);
    // Read data stays put until taken
    a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        ctrl_rvalid && !ctrl_rready |=> ctrl_rvalid && $stable(ctrl_rdata));

endmodule

// File: source/mmu_page_table.sv
`timescale 1ns/10ps

module mmu_page_table import mmu_pkg::*; (
    input  logic         aclk,
    // Control write port
    input  logic         tbl_wr_en,
    input  table_index_t tbl_wr_index,
    input  table_entry_t tbl_wr_entry,
    // Control readback port
    input  logic         tbl_rd_en,
    input  table_index_t tbl_rd_index,
    output table_entry_t tbl_rd_entry,
    // Lookup from the remap stage
    input  logic         lookup_en,
    input  table_index_t lookup_index,
    output table_entry_t lookup_entry
);

    // LUTRAM style, one write and two independent reads
    table_entry_t mem [TABLE_DEPTH];

    // Write port
    always_ff @(posedge aclk) begin
        if (tbl_wr_en) begin
            mem[tbl_wr_index] <= tbl_wr_entry;
        end
    end

    // Readback for the control slave
    // Holds its value between reads so rdata stays stable
    always_ff @(posedge aclk) begin
        if (tbl_rd_en) begin
            tbl_rd_entry <= mem[tbl_rd_index];
        end
    end

    // Lookup, read-first against a write on the same edge
    // Held until the next accepted request
    always_ff @(posedge aclk) begin
        if (lookup_en) begin
            lookup_entry <= mem[lookup_index];
        end
    end

endmodule

// File: source/mmu_addr_remap.sv
`timescale 1ns/10ps

module mmu_addr_remap import mmu_pkg::*; (
    input  logic         aclk,
    input  logic         aresetn,
    // Request from the master
    input  axi_id_t      s_id,
    input  in_addr_t     s_addr,
    input  burst_len_t   s_len,
    input  burst_size_t  s_size,
    input  burst_type_t  s_burst,
    input  logic         s_user,
    input  logic         s_valid,
    output logic         s_ready,
    // Remapped request to memory
    output axi_id_t      m_id,
    output out_addr_t    m_addr,
    output burst_len_t   m_len,
    output burst_size_t  m_size,
    output burst_type_t  m_burst,
    output logic         m_user,
    output logic         m_valid,
    input  logic         m_ready,
    // Page table lookup
    output logic         lookup_en,
    output table_index_t lookup_index,
    input  table_entry_t lookup_entry
);

    in_addr_t req_addr;
    logic     req_user;
    logic     accept;
    logic     bypass;
    logic     entry_err;
    logic [ADDR_BITS_REMAPPED-1:0] entry_page;

    // Stage free when empty or draining this cycle
    assign s_ready = !m_valid || m_ready;
    assign accept  = s_valid && s_ready;

    // ID bits below the MSB, then the top address bits
    assign lookup_index = {s_id[ID_WIDTH-2 -: ID_BITS_USED],
                           s_addr[IN_ADDR_WIDTH-1 -: ADDR_BITS_REMAPPED]};
    // No lookup for privileged IDs
    assign lookup_en = accept && !s_id[ID_WIDTH-1];

    // Valid flag
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_valid <= 1'b0;
        end else if (s_ready) begin
            m_valid <= s_valid;
        end
    end

    // Request payload, loaded alongside the table read
    always_ff @(posedge aclk) begin
        if (accept) begin
            m_id     <= s_id;
            req_addr <= s_addr;
            m_len    <= s_len;
            m_size   <= s_size;
            m_burst  <= s_burst;
            req_user <= s_user;
        end
    end

    // ID MSB set means pass through
    assign bypass     = m_id[ID_WIDTH-1];
    assign entry_err  = lookup_entry[ENTRY_WIDTH-1];
    assign entry_page = lookup_entry[ADDR_BITS_REMAPPED-1:0];

    always_comb begin
        if (bypass) begin
            m_addr = {1'b0, req_addr};
            m_user = req_user;
        end else begin
            // Error bit on top, page over the remapped bits, offset kept
            m_addr = {entry_err | req_user,
                      entry_page,
                      req_addr[IN_ADDR_WIDTH-ADDR_BITS_REMAPPED-1:0]};
            m_user = req_user | entry_err;
        end
    end

    // Held request must not move, table entry included
    a_m_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> m_valid && $stable(m_addr) && $stable(m_id)
            && $stable(m_user) && $stable(m_len) && $stable(m_size) && $stable(m_burst));

endmodule

// File: source/paged_mmu.sv
`timescale 1ns/10ps

module paged_mmu import mmu_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    // AXI-Lite control
    input  ctrl_word_t  ctrl_awaddr, ctrl_wdata, ctrl_araddr,
    input  logic        ctrl_awvalid, ctrl_wvalid, ctrl_bready, ctrl_arvalid, ctrl_rready,
    output logic        ctrl_awready, ctrl_wready, ctrl_bvalid, ctrl_arready, ctrl_rvalid,
    output axi_resp_t   ctrl_bresp, ctrl_rresp,
    output ctrl_word_t  ctrl_rdata,
    // Write address, master side in
    input  axi_id_t     axi_s_awid,
    input  in_addr_t    axi_s_awaddr,
    input  burst_len_t  axi_s_awlen,
    input  burst_size_t axi_s_awsize,
    input  burst_type_t axi_s_awburst,
    input  logic        axi_s_awuser, axi_s_awvalid,
    output logic        axi_s_awready,
    // Read address, master side in
    input  axi_id_t     axi_s_arid,
    input  in_addr_t    axi_s_araddr,
    input  burst_len_t  axi_s_arlen,
    input  burst_size_t axi_s_arsize,
    input  burst_type_t axi_s_arburst,
    input  logic        axi_s_aruser, axi_s_arvalid,
    output logic        axi_s_arready,
    // Write address, memory side out
    output axi_id_t     axi_m_awid,
    output out_addr_t   axi_m_awaddr,
    output burst_len_t  axi_m_awlen,
    output burst_size_t axi_m_awsize,
    output burst_type_t axi_m_awburst,
    output logic        axi_m_awuser, axi_m_awvalid,
    input  logic        axi_m_awready,
    // Read address, memory side out
    output axi_id_t     axi_m_arid,
    output out_addr_t   axi_m_araddr,
    output burst_len_t  axi_m_arlen,
    output burst_size_t axi_m_arsize,
    output burst_type_t axi_m_arburst,
    output logic        axi_m_aruser, axi_m_arvalid,
    input  logic        axi_m_arready
);

    // Control to tables
    logic         aw_tbl_wr_en, ar_tbl_wr_en, aw_tbl_rd_en, ar_tbl_rd_en;
    table_index_t tbl_wr_index, tbl_rd_index;
    table_entry_t tbl_wr_entry, aw_tbl_rd_entry, ar_tbl_rd_entry;
    // Remap stages to tables
    logic         aw_lookup_en, ar_lookup_en;
    table_index_t aw_lookup_index, ar_lookup_index;
    table_entry_t aw_lookup_entry, ar_lookup_entry;

    // Control names match the top level one to one
    mmu_ctrl_slave u_ctrl (.*);

    // Write channel table
    mmu_page_table u_aw_table (
        .aclk, .tbl_wr_en(aw_tbl_wr_en), .tbl_wr_index, .tbl_wr_entry,
        .tbl_rd_en(aw_tbl_rd_en), .tbl_rd_index, .tbl_rd_entry(aw_tbl_rd_entry),
        .lookup_en(aw_lookup_en), .lookup_index(aw_lookup_index),
        .lookup_entry(aw_lookup_entry)
    );

    // Read channel table
    mmu_page_table u_ar_table (
        .aclk, .tbl_wr_en(ar_tbl_wr_en), .tbl_wr_index, .tbl_wr_entry,
        .tbl_rd_en(ar_tbl_rd_en), .tbl_rd_index, .tbl_rd_entry(ar_tbl_rd_entry),
        .lookup_en(ar_lookup_en), .lookup_index(ar_lookup_index),
        .lookup_entry(ar_lookup_entry)
    );

    mmu_addr_remap u_aw_remap (
        .aclk, .aresetn,
        .s_id(axi_s_awid), .s_addr(axi_s_awaddr), .s_len(axi_s_awlen),
        .s_size(axi_s_awsize), .s_burst(axi_s_awburst), .s_user(axi_s_awuser),
        .s_valid(axi_s_awvalid), .s_ready(axi_s_awready),
        .m_id(axi_m_awid), .m_addr(axi_m_awaddr), .m_len(axi_m_awlen),
        .m_size(axi_m_awsize), .m_burst(axi_m_awburst), .m_user(axi_m_awuser),
        .m_valid(axi_m_awvalid), .m_ready(axi_m_awready),
        .lookup_en(aw_lookup_en), .lookup_index(aw_lookup_index),
        .lookup_entry(aw_lookup_entry)
    );

    mmu_addr_remap u_ar_remap (
        .aclk, .aresetn,
        .s_id(axi_s_arid), .s_addr(axi_s_araddr), .s_len(axi_s_arlen),
        .s_size(axi_s_arsize), .s_burst(axi_s_arburst), .s_user(axi_s_aruser),
        .s_valid(axi_s_arvalid), .s_ready(axi_s_arready),
        .m_id(axi_m_arid), .m_addr(axi_m_araddr), .m_len(axi_m_arlen),
        .m_size(axi_m_arsize), .m_burst(axi_m_arburst), .m_user(axi_m_aruser),
        .m_valid(axi_m_arvalid), .m_ready(axi_m_arready),
        .lookup_en(ar_lookup_en), .lookup_index(ar_lookup_index),
        .lookup_entry(ar_lookup_entry)
    );

endmodule

// File: bench/tb_paged_mmu.sv
`timescale 1ns/10ps

module tb_paged_mmu import mmu_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 12;

    logic        aclk, aresetn;
    ctrl_word_t  ctrl_awaddr, ctrl_wdata, ctrl_araddr, ctrl_rdata;
    logic        ctrl_awvalid, ctrl_wvalid, ctrl_bready, ctrl_arvalid, ctrl_rready;
    logic        ctrl_awready, ctrl_wready, ctrl_bvalid, ctrl_arready, ctrl_rvalid;
    axi_resp_t   ctrl_bresp, ctrl_rresp;
    axi_id_t     axi_s_awid, axi_s_arid, axi_m_awid, axi_m_arid;
    in_addr_t    axi_s_awaddr, axi_s_araddr;
    out_addr_t   axi_m_awaddr, axi_m_araddr;
    burst_len_t  axi_s_awlen, axi_s_arlen, axi_m_awlen, axi_m_arlen;
    burst_size_t axi_s_awsize, axi_s_arsize, axi_m_awsize, axi_m_arsize;
    burst_type_t axi_s_awburst, axi_s_arburst, axi_m_awburst, axi_m_arburst;
    logic        axi_s_awuser, axi_s_aruser, axi_s_awvalid, axi_s_arvalid;
    logic        axi_s_awready, axi_s_arready, axi_m_awuser, axi_m_aruser;
    logic        axi_m_awvalid, axi_m_arvalid, axi_m_awready, axi_m_arready;

    // Stimulus table, channel 0 is aw and 1 is ar
    string        t_name  [NUM_TESTS];
    logic         t_chan  [NUM_TESTS];
    axi_id_t      t_id    [NUM_TESTS];
    in_addr_t     t_addr  [NUM_TESTS];
    logic         t_user  [NUM_TESTS];
    table_entry_t t_entry [NUM_TESTS];
    logic         t_stall [NUM_TESTS];

    paged_mmu u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // Generous per-row budget plus margin for reset and the range check
    initial begin
        #((NUM_TESTS * 50 + 200) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Check failed");
    endtask

    task automatic check_addr(string name, out_addr_t exp, out_addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_user(string name, logic exp, logic act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_id(string name, axi_id_t exp, axi_id_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, ctrl_word_t exp, ctrl_word_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(string name, axi_resp_t exp, axi_resp_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // Bypass keeps the address, otherwise error on top, page, then offset
    function automatic out_addr_t expected_addr(axi_id_t id, in_addr_t a, logic u,
                                                table_entry_t e);
        if (id[4]) begin
            return {1'b0, a};
        end
        return {e[7] | u, e[6:0], a[25:0]};
    endfunction

    function automatic logic expected_user(axi_id_t id, logic u, table_entry_t e);
        return id[4] ? u : (u | e[7]);
    endfunction

    // Byte address of a table word
    function automatic ctrl_word_t table_byte(logic chan, table_index_t idx);
        int word;
        word = (chan ? 2048 : 0) + int'(idx);
        return ctrl_word_t'(word * 4);
    endfunction

    task automatic add_test(int i, string name, logic chan, axi_id_t id, logic [6:0] page,
                            logic user, table_entry_t entry, logic stall);
        t_name[i]  = name;
        t_chan[i]  = chan;
        t_id[i]    = id;
        t_addr[i]  = {page, 26'($urandom)};
        t_user[i]  = user;
        t_entry[i] = entry;
        t_stall[i] = stall;
    endtask

    task automatic build_table();
        add_test(0, "aw_remap", 1'b0, 5'h03, 7'h12, 1'b0, 8'h45, 1'b0);
        // Same index as row 0, other channel, other entry
        add_test(1, "ar_same_index", 1'b1, 5'h03, 7'h12, 1'b0, 8'h2a, 1'b0);
        add_test(2, "aw_bypass", 1'b0, 5'h13, 7'h55, 1'b0, 8'h81, 1'b0);
        add_test(3, "ar_bypass_user", 1'b1, 5'h1f, 7'h01, 1'b1, 8'h7c, 1'b0);
        add_test(4, "aw_error_entry", 1'b0, 5'h07, 7'h33, 1'b0, 8'hc4, 1'b0);
        add_test(5, "ar_user_set", 1'b1, 5'h0a, 7'h6b, 1'b1, 8'h33, 1'b0);
        add_test(6, "aw_stall", 1'b0, 5'h02, 7'h20, 1'b0, 8'h11, 1'b1);
        add_test(7, "ar_stall", 1'b1, 5'h0c, 7'h7f, 1'b0, 8'h6e, 1'b1);
        for (int i = 8; i < NUM_TESTS; i++) begin
            add_test(i, $sformatf("random_%0d", i), 1'($urandom), 5'($urandom),
                     7'($urandom), 1'($urandom), 8'($urandom), 1'b0);
        end
    endtask

    task automatic init_inputs();
        aresetn = 1'b0;
        {ctrl_awaddr, ctrl_wdata, ctrl_araddr} = '0;
        {ctrl_awvalid, ctrl_wvalid, ctrl_bready, ctrl_arvalid, ctrl_rready} = '0;
        {axi_s_awid, axi_s_awaddr, axi_s_awlen, axi_s_awsize, axi_s_awburst} = '0;
        {axi_s_arid, axi_s_araddr, axi_s_arlen, axi_s_arsize, axi_s_arburst} = '0;
        {axi_s_awuser, axi_s_aruser, axi_s_awvalid, axi_s_arvalid} = '0;
        axi_m_awready = 1'b1;
        axi_m_arready = 1'b1;
    endtask

    // Called on a falling edge, returns on one
    task automatic ctrl_write(string name, ctrl_word_t addr, ctrl_word_t data);
        ctrl_awaddr  = addr;
        ctrl_wdata   = data;
        ctrl_awvalid = 1'b1;
        ctrl_wvalid  = 1'b1;
        do @(negedge aclk); while (!ctrl_awready);
        // Address and data are taken together
        if (!ctrl_wready) begin
            report_failure({"wready not raised together with awready in ", name});
        end
        // Handshake on the rising edge just passed
        @(negedge aclk);
        ctrl_awvalid = 1'b0;
        ctrl_wvalid  = 1'b0;
        while (!ctrl_bvalid) @(negedge aclk);
        check_resp({name, " bresp"}, RESP_OKAY, ctrl_bresp);
        ctrl_bready = 1'b1;
        @(negedge aclk);
        ctrl_bready = 1'b0;
    endtask

    task automatic ctrl_read(string name, ctrl_word_t addr, output ctrl_word_t data);
        ctrl_araddr  = addr;
        ctrl_arvalid = 1'b1;
        do @(negedge aclk); while (!ctrl_arready);
        @(negedge aclk);
        ctrl_arvalid = 1'b0;
        while (!ctrl_rvalid) @(negedge aclk);
        data = ctrl_rdata;
        check_resp({name, " rresp"}, RESP_OKAY, ctrl_rresp);
        ctrl_rready = 1'b1;
        @(negedge aclk);
        ctrl_rready = 1'b0;
    endtask

    // Attribute word packs len, size and burst
    task automatic drive_req(logic chan, logic valid, axi_id_t id, in_addr_t addr, logic user,
                             ctrl_word_t attr);
        if (chan) begin
            axi_s_arvalid = valid;
            axi_s_arid    = id;
            axi_s_araddr  = addr;
            axi_s_aruser  = user;
            {axi_s_arlen, axi_s_arsize, axi_s_arburst} = attr[12:0];
        end else begin
            axi_s_awvalid = valid;
            axi_s_awid    = id;
            axi_s_awaddr  = addr;
            axi_s_awuser  = user;
            {axi_s_awlen, axi_s_awsize, axi_s_awburst} = attr[12:0];
        end
    endtask

    task automatic set_m_ready(logic chan, logic value);
        if (chan) begin
            axi_m_arready = value;
        end else begin
            axi_m_awready = value;
        end
    endtask

    // Holds valid, returns on the falling edge after the s handshake
    task automatic send_req(logic chan, axi_id_t id, in_addr_t addr, logic user,
                            ctrl_word_t attr);
        drive_req(chan, 1'b1, id, addr, user, attr);
        #1;
        while (!(chan ? axi_s_arready : axi_s_awready)) begin
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
    endtask

    task automatic check_output(string name, logic chan, axi_id_t id, in_addr_t addr, logic u,
                                table_entry_t e, ctrl_word_t attr);
        logic       m_valid;
        logic       m_user;
        axi_id_t    m_id;
        out_addr_t  m_addr;
        ctrl_word_t m_attr;
        m_valid = chan ? axi_m_arvalid : axi_m_awvalid;
        m_user  = chan ? axi_m_aruser : axi_m_awuser;
        m_id    = chan ? axi_m_arid : axi_m_awid;
        m_addr  = chan ? axi_m_araddr : axi_m_awaddr;
        m_attr  = chan ? ctrl_word_t'({axi_m_arlen, axi_m_arsize, axi_m_arburst})
                       : ctrl_word_t'({axi_m_awlen, axi_m_awsize, axi_m_awburst});
        if (!m_valid) begin
            report_failure({"No m valid one cycle after the handshake in ", name});
        end
        check_addr({name, " addr"}, expected_addr(id, addr, u, e), m_addr);
        check_user({name, " user"}, expected_user(id, u, e), m_user);
        check_id({name, " id"}, id, m_id);
        check_word({name, " len size burst"}, attr, m_attr);
    endtask

    initial begin
        table_index_t idx;
        table_entry_t other;
        table_entry_t entry2;
        in_addr_t     addr2;
        ctrl_word_t   word;
        ctrl_word_t   attr;
        ctrl_word_t   attr2;
        void'($urandom(31));
        init_inputs();
        build_table();
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        if (ctrl_awready || ctrl_wready || ctrl_bvalid || ctrl_arready || ctrl_rvalid
            || axi_m_awvalid || axi_m_arvalid) begin
            report_failure("Handshake outputs not low after reset");
        end
        // First word past the read table
        ctrl_read("out_of_range", ctrl_word_t'(CTRL_WORD_COUNT * 4), word);
        check_word("out_of_range", '0, word);
        for (int i = 0; i < NUM_TESTS; i++) begin
            idx   = {t_id[i][3:0], t_addr[i][32:26]};
            other = ~t_entry[i];
            attr  = ctrl_word_t'($urandom) & 32'h1fff;
            // Own table gets the entry, the other one its inverse
            ctrl_write(t_name[i], table_byte(t_chan[i], idx), ctrl_word_t'(t_entry[i]));
            ctrl_write(t_name[i], table_byte(!t_chan[i], idx), ctrl_word_t'(other));
            ctrl_read(t_name[i], table_byte(t_chan[i], idx), word);
            check_word({t_name[i], " readback"}, ctrl_word_t'(t_entry[i]), word);
            ctrl_read(t_name[i], table_byte(!t_chan[i], idx), word);
            check_word({t_name[i], " other readback"}, ctrl_word_t'(other), word);
            if (t_stall[i]) begin
                // Next page up for the queued request
                addr2  = t_addr[i] + (in_addr_t'(1) << 26);
                entry2 = t_entry[i] ^ 8'h0f;
                attr2  = ~attr & 32'h1fff;
                ctrl_write(t_name[i], table_byte(t_chan[i], {t_id[i][3:0], addr2[32:26]}),
                           ctrl_word_t'(entry2));
                set_m_ready(t_chan[i], 1'b0);
            end
            send_req(t_chan[i], t_id[i], t_addr[i], t_user[i], attr);
            check_output(t_name[i], t_chan[i], t_id[i], t_addr[i], t_user[i], t_entry[i], attr);
            if (t_stall[i]) begin
                drive_req(t_chan[i], 1'b1, t_id[i], addr2, t_user[i], attr2);
                // First request must hold while blocked
                repeat (3) begin
                    @(negedge aclk);
                    #1;
                    check_output(t_name[i], t_chan[i], t_id[i], t_addr[i], t_user[i],
                                 t_entry[i], attr);
                    if (t_chan[i] ? axi_s_arready : axi_s_awready) begin
                        report_failure({"s ready high while m side stalled in ", t_name[i]});
                    end
                end
                @(negedge aclk);
                set_m_ready(t_chan[i], 1'b1);
                @(negedge aclk);
                check_output({t_name[i], " second"}, t_chan[i], t_id[i], addr2, t_user[i],
                             entry2, attr2);
            end
            drive_req(t_chan[i], 1'b0, '0, '0, 1'b0, '0);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: paged_mmu.f
source/mmu_pkg.sv
source/mmu_ctrl_slave.sv
source/mmu_page_table.sv
source/mmu_addr_remap.sv
source/paged_mmu.sv
bench/tb_paged_mmu.sv
